// File: design/riscv_isa_pkg.sv
/* RV32I subset definitions: opcodes, core states, ABI register names
   and encoders for the instructions the programs use */
`default_nettype none

package riscv_isa_pkg;

  localparam int WORD_WIDTH = 32;

  typedef enum logic [6:0] {
    OP_COMP    = 7'b0110011,
    OP_COMPIMM = 7'b0010011,
    OP_LOAD    = 7'b0000011,
    OP_STORE   = 7'b0100011,
    OP_BRANCH  = 7'b1100011,
    OP_JAL     = 7'b1101111,
    OP_JALR    = 7'b1100111
  } opcode_e;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_IWAIT,
    ST_EXEC,
    ST_DWAIT
  } core_state_e;

  //////////////////////////////
  // ABI register names
  //////////////////////////////
  localparam logic [4:0] XZERO = 5'd0;
  localparam logic [4:0] XRA   = 5'd1;
  localparam logic [4:0] XSP   = 5'd2;
  localparam logic [4:0] XGP   = 5'd3;
  localparam logic [4:0] XTP   = 5'd4;
  localparam logic [4:0] XT0   = 5'd5;
  localparam logic [4:0] XT1   = 5'd6;
  localparam logic [4:0] XT2   = 5'd7;
  localparam logic [4:0] XS0   = 5'd8;
  localparam logic [4:0] XS1   = 5'd9;
  localparam logic [4:0] XA0   = 5'd10;
  localparam logic [4:0] XA1   = 5'd11;
  localparam logic [4:0] XA2   = 5'd12;
  localparam logic [4:0] XA3   = 5'd13;
  localparam logic [4:0] XA4   = 5'd14;
  localparam logic [4:0] XA5   = 5'd15;
  localparam logic [4:0] XA6   = 5'd16;
  localparam logic [4:0] XA7   = 5'd17;
  localparam logic [4:0] XS2   = 5'd18;
  localparam logic [4:0] XS3   = 5'd19;
  localparam logic [4:0] XS4   = 5'd20;
  localparam logic [4:0] XS5   = 5'd21;
  localparam logic [4:0] XS6   = 5'd22;
  localparam logic [4:0] XS7   = 5'd23;
  localparam logic [4:0] XS8   = 5'd24;
  localparam logic [4:0] XS9   = 5'd25;
  localparam logic [4:0] XS10  = 5'd26;
  localparam logic [4:0] XS11  = 5'd27;
  localparam logic [4:0] XT3   = 5'd28;
  localparam logic [4:0] XT4   = 5'd29;
  localparam logic [4:0] XT5   = 5'd30;
  localparam logic [4:0] XT6   = 5'd31;

  //////////////////////////////
  // Instruction encoders
  //////////////////////////////
  function automatic logic [31:0] ADD(input logic [4:0] rd, rs1, rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, OP_COMP};
  endfunction

  function automatic logic [31:0] ADDI(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OP_COMPIMM};
  endfunction

  function automatic logic [31:0] LW(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, OP_LOAD};
  endfunction

  function automatic logic [31:0] SW(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
  endfunction

  // B-type layout shared by all four branches
  function automatic logic [31:0] enc_branch(input logic [2:0] funct3,
                                             input logic [4:0] rs1, rs2,
                                             input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] BEQ(input logic [4:0] rs1, rs2, input logic [12:0] imm);
    return enc_branch(3'b000, rs1, rs2, imm);
  endfunction

  function automatic logic [31:0] BNE(input logic [4:0] rs1, rs2, input logic [12:0] imm);
    return enc_branch(3'b001, rs1, rs2, imm);
  endfunction

  function automatic logic [31:0] BLT(input logic [4:0] rs1, rs2, input logic [12:0] imm);
    return enc_branch(3'b100, rs1, rs2, imm);
  endfunction

  function automatic logic [31:0] BGE(input logic [4:0] rs1, rs2, input logic [12:0] imm);
    return enc_branch(3'b101, rs1, rs2, imm);
  endfunction

  function automatic logic [31:0] JAL(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  function automatic logic [31:0] JALR(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OP_JALR};
  endfunction

endpackage

`default_nettype wire

// File: design/soc_mem_pkg.sv
/* SoC memory map, memory sizes, data bus request and sort test data */
`default_nettype none

package soc_mem_pkg;

  //////////////////////////////
  // Instruction memory
  //////////////////////////////
  localparam int unsigned IMEM_WORDS   = 64;
  localparam logic [31:0] COUNTER_BASE = 32'h0000_0000;
  localparam logic [31:0] SORT_BASE    = 32'h0000_0080;

  //////////////////////////////
  // Data memory and GPIO
  //////////////////////////////
  // RAM covers bytes 0x000 to 0x3FF
  localparam int unsigned DMEM_WORDS = 256;
  // Below 2048 so one ADDI from x0 reaches it
  localparam logic [31:0] GPIO_ADDR  = 32'h0000_07F0;

  // Sort input, placed after the byte length word
  localparam int unsigned SORT_LEN = 8;
  localparam logic signed [31:0] SORT_INIT [SORT_LEN] = '{
    32'sd5,
    -32'sd3,
    32'sd17,
    32'sd0,
    -32'sd12,
    32'sd8,
    32'sd2,
    -32'sd1
  };

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
  } mem_req_t;

endpackage

`default_nettype wire

// File: design/instr_mem.sv
/* Instruction ROM holding the counter and bubble sort programs,
   answering each granted fetch one cycle later */
`default_nettype none

module instr_mem (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        instr_req_i,
  input  logic [31:0] instr_addr_i,
  output logic        instr_gnt_o,
  output logic [31:0] instr_rdata_o,
  output logic        instr_rvalid_o
);
  import riscv_isa_pkg::*;
  import soc_mem_pkg::*;

  logic [WORD_WIDTH-1:0] rom [IMEM_WORDS];
  logic [$clog2(IMEM_WORDS)-1:0] word_idx;
  logic in_range;
  int unsigned load_idx;

  // Low two address bits ignored
  assign word_idx = instr_addr_i[$clog2(IMEM_WORDS)+1:2];
  assign in_range = instr_addr_i < 32'(IMEM_WORDS * 4);
  assign instr_gnt_o = instr_req_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      instr_rvalid_o <= 1'b0;
    end else begin
      instr_rvalid_o <= instr_req_i && in_range;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_req_i && in_range) begin
      instr_rdata_o <= rom[word_idx];
    end
  end

  //////////////////////////////
  // Program image
  //////////////////////////////
  task automatic put(input logic [31:0] instr);
    rom[load_idx] = instr;
    load_idx++;
  endtask

  initial begin
    for (int i = 0; i < IMEM_WORDS; i++) begin
      rom[i] = '0;
    end

    // Counter: s0 count, s1 down flag, t0 = 15, s2 GPIO pointer
    load_idx = int'(COUNTER_BASE >> 2);
    put(ADDI(XS2, XZERO, GPIO_ADDR[11:0]));  // 00
    put(ADD(XS0, XZERO, XZERO));             // 04
    put(ADD(XS1, XZERO, XZERO));             // 08
    put(ADDI(XT0, XZERO, 12'd15));           // 0c
    put(SW(XS0, XS2, 12'd0));                // 10 loop, show count
    put(BEQ(XS1, XZERO, 13'sd12));           // 14
    put(ADDI(XS0, XS0, -12'sd1));            // 18
    put(JAL(XZERO, 21'sd8));                 // 1c
    put(ADDI(XS0, XS0, 12'd1));              // 20
    put(BNE(XS0, XZERO, 13'sd8));            // 24
    put(ADD(XS1, XZERO, XZERO));             // 28 hit zero, count up
    put(BNE(XS0, XT0, 13'sd8));              // 2c
    put(ADDI(XS1, XZERO, 12'd1));            // 30 hit 15, count down
    put(JAL(XZERO, -21'sd36));               // 34

    // Sort: s0 array base, s1 byte length, s2 i, s3 j, s4 GPIO pointer
    load_idx = int'(SORT_BASE >> 2);
    put(ADDI(XS4, XZERO, GPIO_ADDR[11:0]));  // 80
    put(LW(XS1, XZERO, 12'd0));              // 84
    put(ADDI(XS0, XZERO, 12'd4));            // 88
    put(JAL(XRA, 21'sd32));                  // 8c call sort
    put(ADD(XS3, XS0, XZERO));               // 90 output loop
    put(ADD(XS2, XS0, XS1));                 // 94
    put(LW(XT0, XS3, 12'd0));                // 98
    put(SW(XT0, XS4, 12'd0));                // 9c
    put(ADDI(XS3, XS3, 12'd4));              // a0
    put(BLT(XS3, XS2, -13'sd12));            // a4
    put(JAL(XZERO, 21'sd0));                 // a8 halt
    put(ADD(XS2, XS0, XS1));                 // ac sort, i = last element
    put(ADDI(XS2, XS2, -12'sd4));            // b0
    put(ADD(XS3, XS0, XZERO));               // b4 outer pass
    put(LW(XT0, XS3, 12'd0));                // b8 inner step
    put(LW(XT1, XS3, 12'd4));                // bc
    put(BGE(XT1, XT0, 13'sd12));             // c0 already ordered
    put(SW(XT0, XS3, 12'd4));                // c4 swap
    put(SW(XT1, XS3, 12'd0));                // c8
    put(ADDI(XS3, XS3, 12'd4));              // cc
    put(BLT(XS3, XS2, -13'sd24));            // d0
    put(ADDI(XS2, XS2, -12'sd4));            // d4
    put(BNE(XS2, XS0, -13'sd36));            // d8
    put(JALR(XZERO, XRA, 12'd0));            // dc return
  end

endmodule

`default_nettype wire

// File: design/data_mem.sv
/* Data RAM with one-cycle read and a GPIO output register
   decoded at its own address */
`default_nettype none

module data_mem (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  data_req_i,
  input  soc_mem_pkg::mem_req_t data_bus_i,
  output logic                  data_gnt_o,
  output logic [31:0]           data_rdata_o,
  output logic                  data_rvalid_o,
  output logic [31:0]           gpio_o,
  output logic                  gpio_we_o
);
  import soc_mem_pkg::*;

  logic [31:0] ram [DMEM_WORDS];
  logic [$clog2(DMEM_WORDS)-1:0] word_idx;
  logic in_ram;
  logic is_gpio;

  assign word_idx = data_bus_i.addr[$clog2(DMEM_WORDS)+1:2];
  assign in_ram   = data_bus_i.addr < 32'(DMEM_WORDS * 4);
  assign is_gpio  = data_bus_i.addr[31:2] == GPIO_ADDR[31:2];
  assign data_gnt_o = data_req_i;

  // Byte length at word 0, then the unsorted array
  function automatic logic [31:0] preload_word(input int unsigned idx);
    if (idx == 0) begin
      return 32'(SORT_LEN * 4);
    end
    if (idx <= SORT_LEN) begin
      return SORT_INIT[idx-1];
    end
    return '0;
  endfunction

  initial begin
    for (int unsigned i = 0; i < DMEM_WORDS; i++) begin
      ram[i] = preload_word(i);
    end
  end

  always @(posedge clk) begin
    if (rst_i) begin
      for (int unsigned i = 0; i <= SORT_LEN; i++) begin
        ram[i] <= preload_word(i);
      end
    end else if (data_req_i && data_bus_i.we && in_ram) begin
      ram[word_idx] <= data_bus_i.wdata;
    end
    // Unmapped reads return zero
    if (is_gpio) begin
      data_rdata_o <= gpio_o;
    end else if (in_ram) begin
      data_rdata_o <= ram[word_idx];
    end else begin
      data_rdata_o <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      data_rvalid_o <= 1'b0;
      gpio_o        <= '0;
      gpio_we_o     <= 1'b0;
    end else begin
      data_rvalid_o <= data_req_i;
      gpio_we_o     <= data_req_i && data_bus_i.we && is_gpio;
      if (data_req_i && data_bus_i.we && is_gpio) begin
        gpio_o <= data_bus_i.wdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/core_regfile.sv
/* Core register file, two read ports and one write port, x0 reads zero */
`default_nettype none

module core_regfile (
  input  logic        clk,
  input  logic        rst_i,
  input  logic [4:0]  rs1_addr_i,
  input  logic [4:0]  rs2_addr_i,
  output logic [31:0] rs1_data_o,
  output logic [31:0] rs2_data_o,
  input  logic        we_i,
  input  logic [4:0]  rd_addr_i,
  input  logic [31:0] rd_data_i
);

  // No storage behind x0
  logic [31:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_addr_i != 5'd0) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

// File: design/core_fsm.sv
/* Multi-cycle RV32I subset core: fetch, execute and data access
   sequenced by a four-state FSM */
`default_nettype none

module core_fsm (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  boot_sel_i,
  // Instruction bus
  output logic                  instr_req_o,
  output logic [31:0]           instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic [31:0]           instr_rdata_i,
  input  logic                  instr_rvalid_i,
  // Data bus
  output logic                  data_req_o,
  output soc_mem_pkg::mem_req_t data_bus_o,
  input  logic                  data_gnt_i,
  input  logic [31:0]           data_rdata_i,
  input  logic                  data_rvalid_i,
  // Register file
  output logic [4:0]            rs1_addr_o,
  output logic [4:0]            rs2_addr_o,
  input  logic [31:0]           rs1_data_i,
  input  logic [31:0]           rs2_data_i,
  output logic                  rd_we_o,
  output logic [4:0]            rd_addr_o,
  output logic [31:0]           rd_data_o
);
  import riscv_isa_pkg::*;
  import soc_mem_pkg::*;

  core_state_e           state_q;
  logic [WORD_WIDTH-1:0] pc_q;
  logic [WORD_WIDTH-1:0] instr_q;
  logic [WORD_WIDTH-1:0] load_q;
  logic                  wb_pend_q;

  opcode_e               opcode;
  logic [WORD_WIDTH-1:0] imm_i;
  logic [WORD_WIDTH-1:0] imm_s;
  logic [WORD_WIDTH-1:0] imm_b;
  logic [WORD_WIDTH-1:0] imm_j;
  logic [WORD_WIDTH-1:0] operand_b;
  logic [WORD_WIDTH-1:0] sum;
  logic [WORD_WIDTH-1:0] pc_plus4;
  logic [WORD_WIDTH-1:0] next_pc;
  logic                  take;
  logic                  is_mem;

  //////////////////////////////
  // Decode
  //////////////////////////////
  assign opcode     = opcode_e'(instr_q[6:0]);
  assign rs1_addr_o = instr_q[19:15];
  assign rs2_addr_o = instr_q[24:20];
  assign rd_addr_o  = instr_q[11:7];

  assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
  assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
  assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                  instr_q[11:8], 1'b0};
  assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                  instr_q[30:21], 1'b0};

  // One adder serves ALU ops and load/store addresses
  assign operand_b = (opcode == OP_COMP)  ? rs2_data_i :
                     (opcode == OP_STORE) ? imm_s : imm_i;
  assign sum       = rs1_data_i + operand_b;
  assign pc_plus4  = pc_q + 32'd4;
  assign is_mem    = opcode inside {OP_LOAD, OP_STORE};

  // Funct3 only matters for branches
  always_comb begin
    case (instr_q[14:12])
      3'b000:  take = rs1_data_i == rs2_data_i;
      3'b001:  take = rs1_data_i != rs2_data_i;
      3'b100:  take = $signed(rs1_data_i) < $signed(rs2_data_i);
      3'b101:  take = $signed(rs1_data_i) >= $signed(rs2_data_i);
      default: take = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      OP_BRANCH: next_pc = take ? pc_q + imm_b : pc_plus4;
      OP_JAL:    next_pc = pc_q + imm_j;
      OP_JALR:   next_pc = sum & ~32'd1;
      default:   next_pc = pc_plus4;
    endcase
  end

  //////////////////////////////
  // Bus and writeback
  //////////////////////////////
  assign instr_req_o  = state_q == ST_FETCH;
  assign instr_addr_o = pc_q;
  assign data_req_o   = (state_q == ST_EXEC) && is_mem;
  assign data_bus_o   = '{addr: sum, wdata: rs2_data_i, we: opcode == OP_STORE};

  always_comb begin
    rd_we_o   = 1'b0;
    rd_data_o = sum;
    if (state_q == ST_EXEC) begin
      case (opcode)
        OP_COMP, OP_COMPIMM: rd_we_o = 1'b1;
        OP_JAL, OP_JALR: begin
          rd_we_o   = 1'b1;
          rd_data_o = pc_plus4;
        end
        default: rd_we_o = 1'b0;
      endcase
    end else if (state_q == ST_DWAIT && wb_pend_q && opcode == OP_LOAD) begin
      // Load result lands in the second DWAIT cycle
      rd_we_o   = 1'b1;
      rd_data_o = load_q;
    end
  end

  //////////////////////////////
  // FSM
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= ST_FETCH;
      pc_q      <= boot_sel_i ? SORT_BASE : COUNTER_BASE;
      wb_pend_q <= 1'b0;
    end else begin
      case (state_q)
        ST_FETCH: if (instr_gnt_i) state_q <= ST_IWAIT;
        ST_IWAIT: if (instr_rvalid_i) state_q <= ST_EXEC;
        ST_EXEC: begin
          if (!is_mem || data_gnt_i) begin
            pc_q    <= next_pc;
            state_q <= is_mem ? ST_DWAIT : ST_FETCH;
          end
        end
        ST_DWAIT: begin
          if (wb_pend_q) begin
            wb_pend_q <= 1'b0;
            state_q   <= ST_FETCH;
          end else if (data_rvalid_i) begin
            wb_pend_q <= 1'b1;
          end
        end
        default: state_q <= ST_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IWAIT && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
    if (state_q == ST_DWAIT && data_rvalid_i) begin
      load_q <= data_rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: design/mini_soc.sv
/* Mini SoC top: core, register file, instruction ROM and data RAM with GPIO */
`default_nettype none

module mini_soc (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        boot_sel_i,
  output logic [31:0] gpio_o,
  output logic        gpio_we_o
);
  import soc_mem_pkg::*;

  // Instruction bus
  logic        instr_req;
  logic [31:0] instr_addr;
  logic        instr_gnt;
  logic [31:0] instr_rdata;
  logic        instr_rvalid;

  // Data bus
  logic        data_req;
  mem_req_t    data_bus;
  logic        data_gnt;
  logic [31:0] data_rdata;
  logic        data_rvalid;

  // Register file ports
  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        rd_we;
  logic [4:0]  rd_addr;
  logic [31:0] rd_data;

  core_fsm u_core (
    .clk            (clk),
    .rst_i          (rst_i),
    .boot_sel_i     (boot_sel_i),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rdata_i  (instr_rdata),
    .instr_rvalid_i (instr_rvalid),
    .data_req_o     (data_req),
    .data_bus_o     (data_bus),
    .data_gnt_i     (data_gnt),
    .data_rdata_i   (data_rdata),
    .data_rvalid_i  (data_rvalid),
    .rs1_addr_o     (rs1_addr),
    .rs2_addr_o     (rs2_addr),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .rd_we_o        (rd_we),
    .rd_addr_o      (rd_addr),
    .rd_data_o      (rd_data)
  );

  core_regfile u_regfile (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rd_we),
    .rd_addr_i  (rd_addr),
    .rd_data_i  (rd_data)
  );

  instr_mem u_imem (
    .clk            (clk),
    .rst_i          (rst_i),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_gnt_o    (instr_gnt),
    .instr_rdata_o  (instr_rdata),
    .instr_rvalid_o (instr_rvalid)
  );

  data_mem u_dmem (
    .clk           (clk),
    .rst_i         (rst_i),
    .data_req_i    (data_req),
    .data_bus_i    (data_bus),
    .data_gnt_o    (data_gnt),
    .data_rdata_o  (data_rdata),
    .data_rvalid_o (data_rvalid),
    .gpio_o        (gpio_o),
    .gpio_we_o     (gpio_we_o)
  );

endmodule

`default_nettype wire

// File: sim/mini_soc_checker.sv
/* Bus protocol assertions on the core, attached by bind to core_fsm */
`default_nettype none

module mini_soc_checker (
  input logic                       clk,
  input logic                       rst_i,
  input logic                       instr_req_i,
  input logic [31:0]                instr_addr_i,
  input logic                       instr_rvalid_i,
  input logic                       data_req_i,
  input riscv_isa_pkg::core_state_e state_i
);
  timeunit 1ns;
  timeprecision 100ps;

  import riscv_isa_pkg::*;
  import soc_mem_pkg::*;

  // Fetch answered exactly one cycle later
  assert property (@(posedge clk) disable iff (rst_i) instr_req_i |=> instr_rvalid_i)
    else $error("instr_rvalid missing one cycle after instr_req");

  assert property (@(posedge clk) disable iff (rst_i) instr_rvalid_i |-> $past(instr_req_i))
    else $error("instr_rvalid without a request in the previous cycle");

  // EXEC is the single cycle right after the fetch reply
  assert property (@(posedge clk) disable iff (rst_i)
                   data_req_i |-> $past(state_i == ST_IWAIT && instr_rvalid_i))
    else $error("data_req raised outside ST_EXEC");

  assert property (@(posedge clk) disable iff (rst_i)
                   instr_req_i |-> instr_addr_i < 32'(IMEM_WORDS * 4))
    else $error("instr_addr outside the instruction memory");

endmodule

bind core_fsm mini_soc_checker u_checker (
  .clk            (clk),
  .rst_i          (rst_i),
  .instr_req_i    (instr_req_o),
  .instr_addr_i   (instr_addr_o),
  .instr_rvalid_i (instr_rvalid_i),
  .data_req_i     (data_req_o),
  .state_i        (state_q)
);

`default_nettype wire

// File: sim/mini_soc_tb.sv
/* Mini SoC testbench that boots both programs from a scenario table
   and checks the GPIO output sequence against reference values */
`default_nettype none

module mini_soc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import soc_mem_pkg::*;

  localparam int unsigned TIMEOUT_CYCLES = 2000;
  localparam int unsigned RESET_CYCLES   = 4;
  localparam logic        PROG_COUNTER   = 1'b0;
  localparam logic        PROG_SORT      = 1'b1;

  // One row per boot with strap value, program and pulses to check
  typedef struct packed {
    logic       boot_sel;
    logic       prog_id;
    logic [7:0] pulses;
  } scenario_t;

  localparam int NUM_SCENARIOS = 4;
  localparam scenario_t SCENARIOS [NUM_SCENARIOS] = '{
    '{boot_sel: 1'b0, prog_id: PROG_COUNTER, pulses: 8'd40},
    '{boot_sel: 1'b1, prog_id: PROG_SORT,    pulses: 8'd8},
    '{boot_sel: 1'b0, prog_id: PROG_COUNTER, pulses: 8'd20},
    '{boot_sel: 1'b1, prog_id: PROG_SORT,    pulses: 8'd8}
  };

  logic        clk;
  logic        rst_i;
  logic        boot_sel_i;
  logic [31:0] gpio_o;
  logic        gpio_we_o;

  logic signed [31:0] sorted_vals [SORT_LEN];
  // Cycles from reset release to the first GPIO write, per program
  int unsigned        first_wait [2];

  mini_soc uut (
    .clk        (clk),
    .rst_i      (rst_i),
    .boot_sel_i (boot_sel_i),
    .gpio_o     (gpio_o),
    .gpio_we_o  (gpio_we_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////
  // Triangle wave 0..15..0 with a period of 30 stores
  function automatic logic [31:0] counter_value(input int unsigned idx);
    int unsigned phase;
    phase = idx % 30;
    if (phase <= 15) begin
      return 32'(phase);
    end
    return 32'(30 - phase);
  endfunction

  // Insertion sort into ascending signed order
  task automatic sort_reference();
    logic signed [31:0] key;
    int j;
    for (int i = 0; i < SORT_LEN; i++) begin
      sorted_vals[i] = SORT_INIT[i];
    end
    for (int i = 1; i < SORT_LEN; i++) begin
      key = sorted_vals[i];
      j = i - 1;
      while (j >= 0 && sorted_vals[j] > key) begin
        sorted_vals[j+1] = sorted_vals[j];
        j--;
      end
      sorted_vals[j+1] = key;
    end
  endtask

  //////////////////////////////
  // Checks and waits
  //////////////////////////////
  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h",
                              name, got, exp));
    end
  endtask

  // Each one-cycle pulse is seen at exactly one falling edge
  task automatic wait_for_pulse(input int unsigned num, output int unsigned waited);
    int unsigned cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!gpio_we_o && cycles < TIMEOUT_CYCLES);
    if (!gpio_we_o) begin
      stop_on_error($sformatf("Timed out after %0d cycles waiting for GPIO write %0d",
                              cycles, num));
    end
    waited = cycles;
  endtask

  // Halted program must stay silent
  task automatic expect_quiet();
    for (int unsigned c = 0; c < TIMEOUT_CYCLES; c++) begin
      @(negedge clk);
      if (gpio_we_o) begin
        stop_on_error($sformatf("Unexpected GPIO write %0d cycles after the sort finished",
                                c));
      end
    end
  endtask

  task automatic apply_reset(input logic boot_sel);
    @(negedge clk);
    boot_sel_i = boot_sel;
    rst_i = 1'b1;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_value("gpio_we_o", {31'b0, gpio_we_o}, 32'h0);
      check_value("gpio_o", gpio_o, 32'h0);
    end
    rst_i = 1'b0;
    @(negedge clk);
    check_value("gpio_we_o", {31'b0, gpio_we_o}, 32'h0);
    check_value("gpio_o", gpio_o, 32'h0);
  endtask

  task automatic run_scenario(input scenario_t sc);
    logic [31:0] exp;
    int unsigned waited;
    apply_reset(sc.boot_sel);
    for (int unsigned n = 0; n < sc.pulses; n++) begin
      wait_for_pulse(n, waited);
      // A restored RAM hands the sort its unsorted input again, so timing repeats
      if (n == 0) begin
        if (first_wait[sc.prog_id] == 0) begin
          first_wait[sc.prog_id] = waited;
        end else begin
          check_value("first_write_delay", waited, first_wait[sc.prog_id]);
        end
      end
      if (sc.prog_id == PROG_SORT) begin
        exp = sorted_vals[n];
      end else begin
        exp = counter_value(n);
      end
      check_value($sformatf("gpio_o[%0d]", n), gpio_o, exp);
    end
    if (sc.prog_id == PROG_SORT) begin
      expect_quiet();
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    rst_i = 1'b1;
    boot_sel_i = 1'b0;
    first_wait[0] = 0;
    first_wait[1] = 0;
    sort_reference();
    for (int s = 0; s < NUM_SCENARIOS; s++) begin
      run_scenario(SCENARIOS[s]);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
design/riscv_isa_pkg.sv
design/soc_mem_pkg.sv
design/instr_mem.sv
design/data_mem.sv
design/core_regfile.sv
design/core_fsm.sv
design/mini_soc.sv
sim/mini_soc_checker.sv
sim/mini_soc_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the mini SoC regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module mini_soc_tb -f verilog.f -o mini_soc_sim \
  > build.log 2>&1 \
  && ./obj_dir/mini_soc_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
